//--- hdl/primitive_params.svh
/*
 * Widths, lane counts and table depths of the primitive lookup unit.
 * Lane counts may change; table depths must stay powers of two.
 * NULL_INDEX must stay all ones at INDEX_WIDTH bits.
 */
`ifndef PRIMITIVE_PARAMS_SVH
`define PRIMITIVE_PARAMS_SVH

// ----------------------------------------------------------------------
// Fixed-point format, signed 16.16
// ----------------------------------------------------------------------
`define FIXED_WIDTH 32
`define FRAC_BITS 16

// Primitive indexing
`define INDEX_WIDTH 8
`define NULL_INDEX 8'hFF

// ----------------------------------------------------------------------
// Lanes per query and table sizes
// ----------------------------------------------------------------------
`define BOX_LANES 4
`define SPHERE_LANES 2
`define BOX_DEPTH 8
`define SPHERE_DEPTH 4

// Box that follows the scene offset input
`define MOVABLE_BOX 1

// Table entry of 3 coords, 1 extent and a 24-bit color
`define RAW_WIDTH 152

`endif

//--- hdl/fixedPkg.sv
/*
 * Fixed-point value, three-vector and color types.
 * Values are signed 16.16; arithmetic wraps without saturation.
 * Element 0 of a vec3T is x and sits in the top bits.
 */
`include "primitive_params.svh"

package fixedPkg;

    // ------------------------------------------------------------------
    // Scalar and vector values
    // ------------------------------------------------------------------

    // One signed 16.16 value
    typedef logic signed [`FIXED_WIDTH-1:0] fixedT;

    // Three axes, x first in the upper word
    typedef fixedT [0:2] vec3T;

    // ------------------------------------------------------------------
    // Color
    // ------------------------------------------------------------------

    // Eight bits per channel, red on top
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb8T;

endpackage

//--- hdl/primitivePkg.sv
/*
 * Primitive index, surface and raw table entry types.
 * Surface rule follows the reflection scene: index 1 and up is metal.
 * The null index is not handled here, callers mask it first.
 */
`include "primitive_params.svh"

package primitivePkg;
    import fixedPkg::*;

    // ------------------------------------------------------------------
    // Indexes and surfaces
    // ------------------------------------------------------------------

    // Index into a box or sphere table
    typedef logic [`INDEX_WIDTH-1:0] primIndexT;

    // Material seen by the shading stage
    typedef enum logic {
        surfLambertian = 1'b0,
        surfMetal      = 1'b1
    } surfaceT;

    // ------------------------------------------------------------------
    // Raw table entry, same layout for boxes and spheres
    // ------------------------------------------------------------------

    // Position is box center or sphere center
    // Extent is box half size or sphere radius
    typedef struct packed {
        vec3T  position;
        fixedT extent;
        rgb8T  color;
    } rawEntryT;

    // Metal for every primitive past the ground
    function automatic surfaceT classifySurface(input primIndexT index);
        if (index >= primIndexT'(1)) begin
            return surfMetal;
        end
        return surfLambertian;
    endfunction

endpackage

//--- hdl/primitiveStore.sv
/*
 * Built-in scene of boxes and spheres, read combinationally per lane.
 * Addresses must already be clipped below the table depth.
 * Tables are constant after start-up; no write port.
 */
`timescale 1ns/1ps
`include "primitive_params.svh"

module primitiveStore
    import fixedPkg::*;
    import primitivePkg::*;
(
    input  primIndexT boxAddr[`BOX_LANES],
    input  primIndexT sphereAddr[`SPHERE_LANES],
    output rawEntryT  boxEntry[`BOX_LANES],
    output rawEntryT  sphereEntry[`SPHERE_LANES]
);

    localparam int BOX_ADDR_BITS = $clog2(`BOX_DEPTH);
    localparam int SPHERE_ADDR_BITS = $clog2(`SPHERE_DEPTH);

    logic [`RAW_WIDTH-1:0] boxTable[`BOX_DEPTH];
    logic [`RAW_WIDTH-1:0] sphereTable[`SPHERE_DEPTH];

    // Integer to 16.16
    function automatic fixedT toFixed(input int value);
        return fixedT'(value <<< `FRAC_BITS);
    endfunction

    // Pack one scene entry from whole-unit values
    function automatic rawEntryT makeEntry(input int x, input int y, input int z,
                                           input int extent, input int red,
                                           input int green, input int blue);
        rawEntryT entry;
        entry.position[0] = toFixed(x);
        entry.position[1] = toFixed(y);
        entry.position[2] = toFixed(z);
        entry.extent = toFixed(extent);
        entry.color.red = 8'(red);
        entry.color.green = 8'(green);
        entry.color.blue = 8'(blue);
        return entry;
    endfunction

    // ------------------------------------------------------------------
    // Scene contents
    // ------------------------------------------------------------------
    initial begin
        // Empty slots read as zero
        for (int i = 0; i < `BOX_DEPTH; i++) begin
            boxTable[i] = '0;
        end
        for (int i = 0; i < `SPHERE_DEPTH; i++) begin
            sphereTable[i] = '0;
        end

        // Ground slab
        boxTable[0] = makeEntry(0, -256, 0, 256, 100, 255, 100);
        // Movable box, shifted later by the offset
        boxTable[1] = makeEntry(0, 12, 24, 12, 255, 255, 145);
        boxTable[2] = makeEntry(-25, 12, 0, 12, 255, 70, 85);

        // Single sphere resting on the ground
        sphereTable[0] = makeEntry(0, 16, 0, 16, 255, 255, 0);
    end

    // ------------------------------------------------------------------
    // Lane read ports
    // ------------------------------------------------------------------
    always_comb begin
        for (int lane = 0; lane < `BOX_LANES; lane++) begin
            boxEntry[lane] = rawEntryT'(boxTable[boxAddr[lane][BOX_ADDR_BITS-1:0]]);
        end
        for (int lane = 0; lane < `SPHERE_LANES; lane++) begin
            sphereEntry[lane] =
                rawEntryT'(sphereTable[sphereAddr[lane][SPHERE_ADDR_BITS-1:0]]);
        end
    end

endmodule

//--- hdl/indexWindow.sv
/*
 * Start index and end bound to one clipped index per lane.
 * A lane misses on overflow, on the null index, or past bound or depth.
 * Missed lanes drive address 0 so table reads stay in range.
 */
`timescale 1ns/1ps
`include "primitive_params.svh"

module indexWindow
    import primitivePkg::*;
#(
    parameter int LANES = 4,
    parameter int DEPTH = 8
) (
    input  primIndexT start,
    input  primIndexT bound,
    output primIndexT laneIndex[LANES],
    output logic      laneHit[LANES]
);

    // One extra bit catches the carry out of start plus lane
    localparam int SUM_WIDTH = `INDEX_WIDTH + 1;

    for (genvar lane = 0; lane < LANES; lane++) begin : laneGen
        logic [SUM_WIDTH-1:0] sum;
        primIndexT            index;
        logic                 hit;

        assign sum = {1'b0, start} + SUM_WIDTH'(lane);
        assign index = sum[`INDEX_WIDTH-1:0];

        // All checks must pass
        assign hit = !sum[`INDEX_WIDTH]
                  && (index != `NULL_INDEX)
                  && (index < bound)
                  && (sum < SUM_WIDTH'(DEPTH));

        assign laneHit[lane] = hit;
        assign laneIndex[lane] = hit ? index : '0;
    end

endmodule

//--- hdl/boxDecoder.sv
/*
 * Registered box decode: corners from center and half size.
 * Offset applies only to the movable box and must be stable at the strobe.
 * Outputs hold until the next query; there is no back-pressure.
 */
`timescale 1ns/1ps
`include "primitive_params.svh"

module boxDecoder
    import fixedPkg::*;
    import primitivePkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      query,
    input  primIndexT laneIndex[`BOX_LANES],
    input  logic      laneHit[`BOX_LANES],
    input  rawEntryT  entry[`BOX_LANES],
    input  vec3T      offset,
    output logic      valid,
    output vec3T      boxMin[`BOX_LANES],
    output vec3T      boxMax[`BOX_LANES],
    output rgb8T      color[`BOX_LANES],
    output surfaceT   surface[`BOX_LANES],
    output primIndexT index[`BOX_LANES]
);

    vec3T minNext[`BOX_LANES];
    vec3T maxNext[`BOX_LANES];

    // ------------------------------------------------------------------
    // Corner decode, zero on missed lanes
    // ------------------------------------------------------------------
    always_comb begin
        vec3T shift;
        for (int lane = 0; lane < `BOX_LANES; lane++) begin
            shift = (laneIndex[lane] == primIndexT'(`MOVABLE_BOX)) ? offset : '0;
            for (int axis = 0; axis < 3; axis++) begin
                minNext[lane][axis] =
                    entry[lane].position[axis] - entry[lane].extent + shift[axis];
                maxNext[lane][axis] =
                    entry[lane].position[axis] + entry[lane].extent + shift[axis];
            end
            if (!laneHit[lane]) begin
                minNext[lane] = '0;
                maxNext[lane] = '0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Output stage, loaded on the query strobe
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valid <= 1'b0;
            for (int lane = 0; lane < `BOX_LANES; lane++) begin
                boxMin[lane] <= '0;
                boxMax[lane] <= '0;
                color[lane] <= '0;
                surface[lane] <= surfLambertian;
                index[lane] <= `NULL_INDEX;
            end
        end else begin
            valid <= query;
            if (query) begin
                for (int lane = 0; lane < `BOX_LANES; lane++) begin
                    boxMin[lane] <= minNext[lane];
                    boxMax[lane] <= maxNext[lane];
                    // Miss gives black, lambertian, null
                    color[lane] <= laneHit[lane] ? entry[lane].color : '0;
                    surface[lane] <= laneHit[lane] ? classifySurface(laneIndex[lane])
                                                   : surfLambertian;
                    index[lane] <= laneHit[lane] ? laneIndex[lane] : `NULL_INDEX;
                end
            end
        end
    end

endmodule

//--- hdl/sphereDecoder.sv
/*
 * Registered sphere decode: center, radius, color and surface.
 * Spheres never move, the scene offset is not applied here.
 * Outputs hold until the next query; there is no back-pressure.
 */
`timescale 1ns/1ps
`include "primitive_params.svh"

module sphereDecoder
    import fixedPkg::*;
    import primitivePkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      query,
    input  primIndexT laneIndex[`SPHERE_LANES],
    input  logic      laneHit[`SPHERE_LANES],
    input  rawEntryT  entry[`SPHERE_LANES],
    output logic      valid,
    output vec3T      center[`SPHERE_LANES],
    output fixedT     radius[`SPHERE_LANES],
    output rgb8T      color[`SPHERE_LANES],
    output surfaceT   surface[`SPHERE_LANES],
    output primIndexT index[`SPHERE_LANES]
);

    // ------------------------------------------------------------------
    // Output stage, missed lanes load zeros and the null index
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valid <= 1'b0;
            for (int lane = 0; lane < `SPHERE_LANES; lane++) begin
                center[lane] <= '0;
                radius[lane] <= '0;
                color[lane] <= '0;
                surface[lane] <= surfLambertian;
                index[lane] <= `NULL_INDEX;
            end
        end else begin
            valid <= query;
            if (query) begin
                for (int lane = 0; lane < `SPHERE_LANES; lane++) begin
                    center[lane] <= laneHit[lane] ? entry[lane].position : '0;
                    radius[lane] <= laneHit[lane] ? entry[lane].extent : '0;
                    color[lane] <= laneHit[lane] ? entry[lane].color : '0;
                    // Empty slots still classify by index
                    surface[lane] <= laneHit[lane] ? classifySurface(laneIndex[lane])
                                                   : surfLambertian;
                    index[lane] <= laneHit[lane] ? laneIndex[lane] : `NULL_INDEX;
                end
            end
        end
    end

endmodule

//--- hdl/primitiveUnit.sv
/*
 * Primitive lookup unit, one box port and one sphere port.
 * Query strobe in cycle n gives valid and lane data in cycle n+1.
 * Box and sphere paths are independent; consumers must take each result.
 */
`timescale 1ns/1ps
`include "primitive_params.svh"

module primitiveUnit
    import fixedPkg::*;
    import primitivePkg::*;
(
    input  logic      clk,
    input  logic      rstN,

    // Box query
    input  logic      boxQuery,
    input  primIndexT boxStart,
    input  primIndexT boxEnd,
    input  vec3T      offset,

    // Sphere query
    input  logic      sphereQuery,
    input  primIndexT sphereStart,
    input  primIndexT sphereEnd,

    // Box results
    output logic      boxValid,
    output vec3T      boxMin[`BOX_LANES],
    output vec3T      boxMax[`BOX_LANES],
    output rgb8T      boxColor[`BOX_LANES],
    output surfaceT   boxSurface[`BOX_LANES],
    output primIndexT boxIndex[`BOX_LANES],

    // Sphere results
    output logic      sphereValid,
    output vec3T      sphereCenter[`SPHERE_LANES],
    output fixedT     sphereRadius[`SPHERE_LANES],
    output rgb8T      sphereColor[`SPHERE_LANES],
    output surfaceT   sphereSurface[`SPHERE_LANES],
    output primIndexT sphereIndex[`SPHERE_LANES]
);

    // Clipped lane addresses and hit flags
    primIndexT boxAddr[`BOX_LANES];
    logic      boxHit[`BOX_LANES];
    primIndexT sphereAddr[`SPHERE_LANES];
    logic      sphereHit[`SPHERE_LANES];

    // Raw entries from the scene tables
    rawEntryT  boxEntry[`BOX_LANES];
    rawEntryT  sphereEntry[`SPHERE_LANES];

    // ------------------------------------------------------------------
    // Index windows
    // ------------------------------------------------------------------
    indexWindow #(.LANES(`BOX_LANES), .DEPTH(`BOX_DEPTH)) boxWindow0 (
        .start     (boxStart),
        .bound     (boxEnd),
        .laneIndex (boxAddr),
        .laneHit   (boxHit)
    );

    indexWindow #(.LANES(`SPHERE_LANES), .DEPTH(`SPHERE_DEPTH)) sphereWindow0 (
        .start     (sphereStart),
        .bound     (sphereEnd),
        .laneIndex (sphereAddr),
        .laneHit   (sphereHit)
    );

    // Scene tables, combinational read
    primitiveStore store0 (
        .boxAddr     (boxAddr),
        .sphereAddr  (sphereAddr),
        .boxEntry    (boxEntry),
        .sphereEntry (sphereEntry)
    );

    // ------------------------------------------------------------------
    // Decode and register stage
    // ------------------------------------------------------------------
    boxDecoder boxDec0 (
        .clk       (clk),
        .rstN      (rstN),
        .query     (boxQuery),
        .laneIndex (boxAddr),
        .laneHit   (boxHit),
        .entry     (boxEntry),
        .offset    (offset),
        .valid     (boxValid),
        .boxMin    (boxMin),
        .boxMax    (boxMax),
        .color     (boxColor),
        .surface   (boxSurface),
        .index     (boxIndex)
    );

    sphereDecoder sphereDec0 (
        .clk       (clk),
        .rstN      (rstN),
        .query     (sphereQuery),
        .laneIndex (sphereAddr),
        .laneHit   (sphereHit),
        .entry     (sphereEntry),
        .valid     (sphereValid),
        .center    (sphereCenter),
        .radius    (sphereRadius),
        .color     (sphereColor),
        .surface   (sphereSurface),
        .index     (sphereIndex)
    );

endmodule

//--- sim/primitiveUnitTb.sv
/*
 * Directed testbench for the primitive lookup unit.
 * Expected lane data comes from a local copy of the built-in scene.
 * Inputs change on the falling edge, outputs are checked there too.
 */
`timescale 1ns/1ps
`include "primitive_params.svh"

module primitiveUnitTb
    import fixedPkg::*;
    import primitivePkg::*;
();

    // Reset 8, five directed tests, 21 streaming cycles, some slack
    localparam int TEST_CYCLES = 8 + 2 + 2 + 6 + 2 + 2 + 21 + 10;
    localparam int TIMEOUT_NS = TEST_CYCLES * 8 + 400;

    logic      clk;
    logic      rstN;
    logic      boxQuery;
    primIndexT boxStart;
    primIndexT boxEnd;
    vec3T      offset;
    logic      sphereQuery;
    primIndexT sphereStart;
    primIndexT sphereEnd;

    logic      boxValid;
    vec3T      boxMin[`BOX_LANES];
    vec3T      boxMax[`BOX_LANES];
    rgb8T      boxColor[`BOX_LANES];
    surfaceT   boxSurface[`BOX_LANES];
    primIndexT boxIndex[`BOX_LANES];
    logic      sphereValid;
    vec3T      sphereCenter[`SPHERE_LANES];
    fixedT     sphereRadius[`SPHERE_LANES];
    rgb8T      sphereColor[`SPHERE_LANES];
    surfaceT   sphereSurface[`SPHERE_LANES];
    primIndexT sphereIndex[`SPHERE_LANES];

    int     valueErrors = 0;
    int     protocolErrors = 0;
    integer seed = 85;

    // Scene model, whole units
    int   boxPos[`BOX_DEPTH][3];
    int   boxHalf[`BOX_DEPTH];
    rgb8T boxRgb[`BOX_DEPTH];
    int   spherePos[`SPHERE_DEPTH][3];
    int   sphereRad[`SPHERE_DEPTH];
    rgb8T sphereRgb[`SPHERE_DEPTH];

    primitiveUnit dut0 (
        .clk(clk), .rstN(rstN),
        .boxQuery(boxQuery), .boxStart(boxStart), .boxEnd(boxEnd), .offset(offset),
        .sphereQuery(sphereQuery), .sphereStart(sphereStart), .sphereEnd(sphereEnd),
        .boxValid(boxValid), .boxMin(boxMin), .boxMax(boxMax), .boxColor(boxColor),
        .boxSurface(boxSurface), .boxIndex(boxIndex),
        .sphereValid(sphereValid), .sphereCenter(sphereCenter),
        .sphereRadius(sphereRadius), .sphereColor(sphereColor),
        .sphereSurface(sphereSurface), .sphereIndex(sphereIndex)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // ----------------------------------------------------------------------
    // Scene model and window rules
    // ----------------------------------------------------------------------
    function automatic fixedT toFixed(input int value);
        return fixedT'(value * (1 << `FRAC_BITS));
    endfunction

    // Overflow and null both land at 255 and up
    function automatic bit laneHits(input int idx, input int bound, input int depth);
        return (idx < 255) && (idx < bound) && (idx < depth);
    endfunction

    task automatic loadScene();
        for (int i = 0; i < `BOX_DEPTH; i++) begin
            boxPos[i] = '{0, 0, 0};
            boxHalf[i] = 0;
            boxRgb[i] = '0;
        end
        for (int i = 0; i < `SPHERE_DEPTH; i++) begin
            spherePos[i] = '{0, 0, 0};
            sphereRad[i] = 0;
            sphereRgb[i] = '0;
        end
        // Ground, movable box, red box
        boxPos[0] = '{0, -256, 0};
        boxHalf[0] = 256;
        boxRgb[0] = {8'd100, 8'd255, 8'd100};
        boxPos[1] = '{0, 12, 24};
        boxHalf[1] = 12;
        boxRgb[1] = {8'd255, 8'd255, 8'd145};
        boxPos[2] = '{-25, 12, 0};
        boxHalf[2] = 12;
        boxRgb[2] = {8'd255, 8'd70, 8'd85};
        spherePos[0] = '{0, 16, 0};
        sphereRad[0] = 16;
        sphereRgb[0] = {8'd255, 8'd255, 8'd0};
    endtask

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic checkVec3(input string name, input vec3T expected, input vec3T actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkFixed(input string name, input fixedT expected, input fixedT actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkColor(input string name, input rgb8T expected, input rgb8T actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkSurface(input string name, input surfaceT expected,
                                input surfaceT actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkIndex(input string name, input primIndexT expected,
                              input primIndexT actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic checkStrobe(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("%s was %b when %b was expected at %0t", name, actual, expected, $time);
            protocolErrors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Lane checks against the model
    // ----------------------------------------------------------------------
    task automatic checkBoxLanes(input int start, input int bound);
        int        idx;
        vec3T      expMin;
        vec3T      expMax;
        rgb8T      expColor;
        surfaceT   expSurf;
        primIndexT expIndex;
        for (int lane = 0; lane < `BOX_LANES; lane++) begin
            idx = start + lane;
            expMin = '0;
            expMax = '0;
            expColor = '0;
            expSurf = surfLambertian;
            expIndex = `NULL_INDEX;
            if (laneHits(idx, bound, `BOX_DEPTH)) begin
                for (int axis = 0; axis < 3; axis++) begin
                    expMin[axis] = toFixed(boxPos[idx][axis] - boxHalf[idx]);
                    expMax[axis] = toFixed(boxPos[idx][axis] + boxHalf[idx]);
                    // Only the movable box follows the offset
                    if (idx == `MOVABLE_BOX) begin
                        expMin[axis] = expMin[axis] + offset[axis];
                        expMax[axis] = expMax[axis] + offset[axis];
                    end
                end
                expColor = boxRgb[idx];
                expSurf = (idx >= 1) ? surfMetal : surfLambertian;
                expIndex = primIndexT'(idx);
            end
            checkVec3($sformatf("boxMin[%0d]", lane), expMin, boxMin[lane]);
            checkVec3($sformatf("boxMax[%0d]", lane), expMax, boxMax[lane]);
            checkColor($sformatf("boxColor[%0d]", lane), expColor, boxColor[lane]);
            checkSurface($sformatf("boxSurface[%0d]", lane), expSurf, boxSurface[lane]);
            checkIndex($sformatf("boxIndex[%0d]", lane), expIndex, boxIndex[lane]);
        end
    endtask

    task automatic checkSphereLanes(input int start, input int bound);
        int        idx;
        vec3T      expCenter;
        fixedT     expRadius;
        rgb8T      expColor;
        surfaceT   expSurf;
        primIndexT expIndex;
        for (int lane = 0; lane < `SPHERE_LANES; lane++) begin
            idx = start + lane;
            expCenter = '0;
            expRadius = '0;
            expColor = '0;
            expSurf = surfLambertian;
            expIndex = `NULL_INDEX;
            if (laneHits(idx, bound, `SPHERE_DEPTH)) begin
                for (int axis = 0; axis < 3; axis++) begin
                    expCenter[axis] = toFixed(spherePos[idx][axis]);
                end
                expRadius = toFixed(sphereRad[idx]);
                expColor = sphereRgb[idx];
                expSurf = (idx >= 1) ? surfMetal : surfLambertian;
                expIndex = primIndexT'(idx);
            end
            checkVec3($sformatf("sphereCenter[%0d]", lane), expCenter, sphereCenter[lane]);
            checkFixed($sformatf("sphereRadius[%0d]", lane), expRadius, sphereRadius[lane]);
            checkColor($sformatf("sphereColor[%0d]", lane), expColor, sphereColor[lane]);
            checkSurface($sformatf("sphereSurface[%0d]", lane), expSurf,
                         sphereSurface[lane]);
            checkIndex($sformatf("sphereIndex[%0d]", lane), expIndex, sphereIndex[lane]);
        end
    endtask

    // One strobe, result exactly one cycle later, strobe gone the cycle after
    // Lane data must hold while the start index moves without a strobe
    task automatic runBoxQuery(input primIndexT start, input primIndexT bound);
        checkStrobe("boxValid before query", 1'b0, boxValid);
        boxQuery = 1'b1;
        boxStart = start;
        boxEnd = bound;
        @(negedge clk);
        boxQuery = 1'b0;
        boxStart = ~start;
        checkStrobe("boxValid one cycle after query", 1'b1, boxValid);
        checkBoxLanes(int'(start), int'(bound));
        @(negedge clk);
        checkStrobe("boxValid two cycles after query", 1'b0, boxValid);
        checkBoxLanes(int'(start), int'(bound));
    endtask

    task automatic runSphereQuery(input primIndexT start, input primIndexT bound);
        checkStrobe("sphereValid before query", 1'b0, sphereValid);
        sphereQuery = 1'b1;
        sphereStart = start;
        sphereEnd = bound;
        @(negedge clk);
        sphereQuery = 1'b0;
        sphereStart = ~start;
        checkStrobe("sphereValid one cycle after query", 1'b1, sphereValid);
        checkSphereLanes(int'(start), int'(bound));
        @(negedge clk);
        checkStrobe("sphereValid two cycles after query", 1'b0, sphereValid);
        checkSphereLanes(int'(start), int'(bound));
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic testResetState();
        checkStrobe("boxValid after reset", 1'b0, boxValid);
        checkStrobe("sphereValid after reset", 1'b0, sphereValid);
        // Null start makes every lane a miss in the model
        checkBoxLanes(255, 0);
        checkSphereLanes(255, 0);
    endtask

    task automatic testBoxWindow();
        runBoxQuery(8'd0, 8'd8);
    endtask

    task automatic testClipping();
        runBoxQuery(8'd1, 8'd2);
        runBoxQuery(`NULL_INDEX, 8'd8);
        runBoxQuery(8'd6, 8'd8);
    endtask

    task automatic testMovableOffset();
        offset[0] = toFixed(3);
        offset[1] = toFixed(-5) + fixedT'(32'h0000_8000);
        offset[2] = toFixed(7);
        runBoxQuery(8'd0, 8'd8);
        offset = '0;
    endtask

    task automatic testSphereQuery();
        runSphereQuery(8'd0, 8'd4);
    endtask

    // Query every cycle, check the previous one while driving the next
    task automatic testStreaming();
        logic [31:0] r;
        primIndexT   bStart;
        primIndexT   bEnd;
        primIndexT   sStart;
        primIndexT   sEnd;
        for (int i = 0; i <= 20; i++) begin
            if (i > 0) begin
                checkStrobe("boxValid while streaming", 1'b1, boxValid);
                checkStrobe("sphereValid while streaming", 1'b1, sphereValid);
                checkBoxLanes(int'(bStart), int'(bEnd));
                checkSphereLanes(int'(sStart), int'(sEnd));
            end
            if (i < 20) begin
                r = $random(seed);
                // Mostly small starts, sometimes near the top of the range
                bStart = r[8] ? r[7:0] : {4'h0, r[3:0]};
                bEnd = {4'h0, r[19:16]};
                r = $random(seed);
                sStart = r[8] ? r[7:0] : {5'h00, r[2:0]};
                sEnd = {5'h00, r[18:16]};
                boxQuery = 1'b1;
                boxStart = bStart;
                boxEnd = bEnd;
                sphereQuery = 1'b1;
                sphereStart = sStart;
                sphereEnd = sEnd;
            end else begin
                boxQuery = 1'b0;
                sphereQuery = 1'b0;
            end
            @(negedge clk);
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        boxQuery = 1'b0;
        boxStart = '0;
        boxEnd = '0;
        offset = '0;
        sphereQuery = 1'b0;
        sphereStart = '0;
        sphereEnd = '0;
        loadScene();
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        testResetState();
        testBoxWindow();
        testClipping();
        testMovableOffset();
        testSphereQuery();
        testStreaming();

        $display("Run complete: %0d value errors, %0d protocol errors",
                 valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the tests did not complete", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- project.f
+incdir+hdl
hdl/fixedPkg.sv
hdl/primitivePkg.sv
hdl/primitiveStore.sv
hdl/indexWindow.sv
hdl/boxDecoder.sv
hdl/sphereDecoder.sv
hdl/primitiveUnit.sv
sim/primitiveUnitTb.sv

//--- run.sh
#!/bin/sh
# Build and run the primitive lookup unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module primitiveUnitTb \
    -Mdir obj_dir -o primitiveUnitSim

output=$(./obj_dir/primitiveUnitSim)
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi
